/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // bus widths
  localparam int ADDR_W = 64;
  localparam int WORD_W = 64;
  localparam int MEM_TAG_W = 4;

  // icache geometry, direct mapped, one word per line
  localparam int IC_IDX_W = 5;
  localparam int IC_TAG_W = 8;
  localparam int IC_LINES = 2 ** IC_IDX_W;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [MEM_TAG_W-1:0] mem_tag_t;  // 0 means no transaction
  typedef logic [IC_IDX_W-1:0]  ic_idx_t;   // addr[7:3]
  typedef logic [IC_TAG_W-1:0]  ic_tag_t;   // addr[15:8]

  // memory bus command
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // default sizes, overridden from the top level
  localparam int MSHR_DEPTH_DEF = 4;
  localparam int REQ_ID_W_DEF = 4;

endpackage

`default_nettype wire

/* source/icache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_mem (
  input  wire logic             clock,
  input  wire logic             rst_n,
  input  wire mem_pkg::ic_idx_t rd_idx,
  input  wire mem_pkg::ic_tag_t rd_tag,
  input  wire logic             wr_en,
  input  wire mem_pkg::ic_idx_t wr_idx,
  input  wire mem_pkg::ic_tag_t wr_tag,
  input  wire mem_pkg::word_t   wr_data,
  output mem_pkg::word_t        rd_data,
  output logic                  rd_hit
);

  logic [mem_pkg::IC_LINES-1:0] valid;
  mem_pkg::ic_tag_t             tags  [mem_pkg::IC_LINES];
  mem_pkg::word_t               lines [mem_pkg::IC_LINES];

  // read port is combinational
  assign rd_data = lines[rd_idx];
  assign rd_hit  = valid[rd_idx] && (tags[rd_idx] == rd_tag);

  // valid bits, all lines empty out of reset
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clock) begin
    if (wr_en) begin
      tags[wr_idx]  <= wr_tag;
      lines[wr_idx] <= wr_data;  // whole line replaced on fill
    end
  end

endmodule

`default_nettype wire

/* source/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              fetch_en,
  input  wire mem_pkg::addr_t    fetch_addr,
  output mem_pkg::word_t         fetch_data,
  output logic                   fetch_valid,
  output mem_pkg::ic_idx_t       rd_idx,
  output mem_pkg::ic_tag_t       rd_tag,
  input  wire mem_pkg::word_t    rd_data,
  input  wire logic              rd_hit,
  output logic                   wr_en,
  output mem_pkg::ic_idx_t       wr_idx,
  output mem_pkg::ic_tag_t       wr_tag,
  output mem_pkg::word_t         wr_data,
  output mem_pkg::bus_cmd_e      i_command,
  output mem_pkg::addr_t         i_addr,
  input  wire mem_pkg::mem_tag_t i_response,
  input  wire logic              i_reply,
  input  wire mem_pkg::word_t    mem2proc_data,
  input  wire mem_pkg::mem_tag_t mem2proc_tag
);

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REQ,   // load on the bus until accepted
    IC_WAIT   // waiting for the tagged reply
  } ic_state_e;

  ic_state_e         state;
  ic_state_e         state_nx;
  mem_pkg::ic_idx_t  miss_idx;
  mem_pkg::ic_tag_t  miss_tag;
  mem_pkg::mem_tag_t held_tag;  // tag handed out by memory
  logic              miss;
  logic              fill;

  // lookup straight from the fetch address
  assign rd_idx      = fetch_addr[7:3];
  assign rd_tag      = fetch_addr[15:8];
  assign fetch_data  = rd_data;
  assign fetch_valid = fetch_en && rd_hit;

  assign miss = fetch_en && !rd_hit && (state == IC_IDLE);
  // replies for other tags belong to someone else
  assign fill = (state == IC_WAIT) && i_reply && (mem2proc_tag == held_tag);

  // fill write lands at the edge after the reply
  assign wr_en   = fill;
  assign wr_idx  = miss_idx;
  assign wr_tag  = miss_tag;
  assign wr_data = mem2proc_data;

  assign i_command = (state == IC_REQ) ? mem_pkg::BUS_LOAD : mem_pkg::BUS_NONE;
  assign i_addr    = {48'h0, miss_tag, miss_idx, 3'b000};  // line aligned

  always_comb begin
    state_nx = state;
    case (state)
      IC_IDLE: begin
        if (miss) state_nx = IC_REQ;
      end
      IC_REQ: begin
        if (i_response != '0) state_nx = IC_WAIT;  // 0 means retry
      end
      IC_WAIT: begin
        if (fill) state_nx = IC_IDLE;
      end
      default: state_nx = IC_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= IC_IDLE;
    end else begin
      state <= state_nx;
    end
  end

  // miss address and memory tag
  always_ff @(posedge clock) begin
    if (miss) begin
      miss_idx <= rd_idx;
      miss_tag <= rd_tag;
    end
    if ((state == IC_REQ) && (i_response != '0)) begin
      held_tag <= i_response;
    end
  end

endmodule

`default_nettype wire

/* source/mshr.sv */
`timescale 1ns/1ps
`default_nettype none

module mshr #(
  parameter int MSHR_DEPTH = mem_pkg::MSHR_DEPTH_DEF,
  parameter int REQ_ID_W   = mem_pkg::REQ_ID_W_DEF
) (
  input  wire logic                clock,
  input  wire logic                rst_n,
  input  wire logic                dreq_en,
  input  wire logic                dreq_store,
  input  wire mem_pkg::addr_t      dreq_addr,
  input  wire mem_pkg::word_t      dreq_data,
  input  wire logic [REQ_ID_W-1:0] dreq_id,
  output logic                     mshr_free,
  output logic                     load_done,
  output mem_pkg::word_t           load_data,
  output logic [REQ_ID_W-1:0]      load_id,
  output mem_pkg::bus_cmd_e        d_command,
  output mem_pkg::addr_t           d_addr,
  output mem_pkg::word_t           d_data,
  input  wire mem_pkg::mem_tag_t   d_response,
  input  wire logic                d_reply,
  input  wire mem_pkg::word_t      mem2proc_data,
  input  wire mem_pkg::mem_tag_t   mem2proc_tag
);

  localparam int PTR_W = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;
  localparam int CNT_W = $clog2(MSHR_DEPTH + 1);

  // entry payload
  logic                q_store [MSHR_DEPTH];
  mem_pkg::addr_t      q_addr  [MSHR_DEPTH];
  mem_pkg::word_t      q_data  [MSHR_DEPTH];
  logic [REQ_ID_W-1:0] q_id    [MSHR_DEPTH];

  logic [PTR_W-1:0]  head;
  logic [PTR_W-1:0]  tail;
  logic [CNT_W-1:0]  count;
  logic              issued;    // head is on its way to memory
  mem_pkg::mem_tag_t held_tag;  // tag of the outstanding head load

  logic push;
  logic head_valid;
  logic accepted;
  logic store_pop;
  logic load_hit;
  logic pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(MSHR_DEPTH - 1)) begin
      return '0;
    end
    return p + PTR_W'(1);
  endfunction

  assign mshr_free  = (count != CNT_W'(MSHR_DEPTH));
  assign push       = dreq_en && mshr_free;  // requests while full are dropped
  assign head_valid = (count != '0);

  // only the head goes out, one access at a time
  always_comb begin
    d_command = mem_pkg::BUS_NONE;
    if (head_valid && !issued) begin
      d_command = q_store[head] ? mem_pkg::BUS_STORE : mem_pkg::BUS_LOAD;
    end
  end

  assign d_addr = q_addr[head];
  assign d_data = q_data[head];

  assign accepted  = (d_command != mem_pkg::BUS_NONE) && (d_response != '0);
  assign store_pop = accepted && q_store[head];  // stores need no reply
  assign load_hit  = issued && d_reply && (mem2proc_tag == held_tag);
  assign pop       = store_pop || load_hit;

  always_ff @(posedge clock) begin
    if (push) begin
      q_store[tail] <= dreq_store;
      q_addr[tail]  <= dreq_addr;
      q_data[tail]  <= dreq_data;
      q_id[tail]    <= dreq_id;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      issued    <= 1'b0;
      held_tag  <= '0;
      load_done <= 1'b0;
    end else begin
      if (push) tail <= ptr_inc(tail);
      if (pop) head <= ptr_inc(head);
      count <= count + CNT_W'(push) - CNT_W'(pop);
      if (pop) begin
        issued <= 1'b0;
      end else if (accepted) begin
        issued   <= 1'b1;  // a load, now waiting on its tag
        held_tag <= d_response;
      end
      load_done <= load_hit;  // pulse the cycle after the reply
    end
  end

  // load result
  always_ff @(posedge clock) begin
    if (load_hit) begin
      load_data <= mem2proc_data;
      load_id   <= q_id[head];
    end
  end

endmodule

`default_nettype wire

/* source/mem_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bus_arbiter (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire mem_pkg::bus_cmd_e i_command,
  input  wire mem_pkg::addr_t    i_addr,
  input  wire mem_pkg::bus_cmd_e d_command,
  input  wire mem_pkg::addr_t    d_addr,
  input  wire mem_pkg::word_t    d_data,
  output mem_pkg::bus_cmd_e      proc2mem_command,
  output mem_pkg::addr_t         proc2mem_addr,
  output mem_pkg::word_t         proc2mem_data,
  input  wire mem_pkg::mem_tag_t mem2proc_response,
  input  wire mem_pkg::mem_tag_t mem2proc_tag,
  output mem_pkg::mem_tag_t      i_response,
  output mem_pkg::mem_tag_t      d_response,
  output logic                   i_reply,
  output logic                   d_reply
);

  localparam int N_TAGS = 2 ** $bits(mem_pkg::mem_tag_t);

  logic [N_TAGS-1:0] own_v;  // tag outstanding
  logic [N_TAGS-1:0] own_d;  // owner is the data side
  logic              d_sel;
  logic              load_acc;
  logic              reply_v;

  // data side wins whenever it asks
  assign d_sel = (d_command != mem_pkg::BUS_NONE);

  assign proc2mem_command = d_sel ? d_command : i_command;
  assign proc2mem_addr    = d_sel ? d_addr : i_addr;
  assign proc2mem_data    = d_data;

  // loser sees 0 and retries
  assign d_response = d_sel ? mem2proc_response : '0;
  assign i_response = (!d_sel && (i_command != mem_pkg::BUS_NONE)) ? mem2proc_response : '0;

  assign load_acc = (proc2mem_command == mem_pkg::BUS_LOAD) && (mem2proc_response != '0);
  assign reply_v  = (mem2proc_tag != '0) && own_v[mem2proc_tag];
  assign i_reply  = reply_v && !own_d[mem2proc_tag];
  assign d_reply  = reply_v && own_d[mem2proc_tag];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      own_v <= '0;
      own_d <= '0;
    end else begin
      if (mem2proc_tag != '0) own_v[mem2proc_tag] <= 1'b0;
      if (load_acc) begin  // new owner wins over a same-cycle release
        own_v[mem2proc_response] <= 1'b1;
        own_d[mem2proc_response] <= d_sel;
      end
    end
  end

endmodule

`default_nettype wire

/* source/mem_system.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_system #(
  parameter int MSHR_DEPTH = mem_pkg::MSHR_DEPTH_DEF,
  parameter int REQ_ID_W   = mem_pkg::REQ_ID_W_DEF
) (
  input  wire logic                clock,
  input  wire logic                rst_n,
  // fetch side
  input  wire logic                fetch_en,
  input  wire mem_pkg::addr_t      fetch_addr,
  output mem_pkg::word_t           fetch_data,
  output logic                     fetch_valid,
  // data side
  input  wire logic                dreq_en,
  input  wire logic                dreq_store,
  input  wire mem_pkg::addr_t      dreq_addr,
  input  wire mem_pkg::word_t      dreq_data,
  input  wire logic [REQ_ID_W-1:0] dreq_id,
  output logic                     mshr_free,
  output logic                     load_done,
  output mem_pkg::word_t           load_data,
  output logic [REQ_ID_W-1:0]      load_id,
  // memory bus
  output mem_pkg::bus_cmd_e        proc2mem_command,
  output mem_pkg::addr_t           proc2mem_addr,
  output mem_pkg::word_t           proc2mem_data,
  input  wire mem_pkg::mem_tag_t   mem2proc_response,
  input  wire mem_pkg::word_t      mem2proc_data,
  input  wire mem_pkg::mem_tag_t   mem2proc_tag
);

  // icache array wires
  mem_pkg::ic_idx_t  ic_rd_idx;
  mem_pkg::ic_tag_t  ic_rd_tag;
  mem_pkg::word_t    ic_rd_data;
  logic              ic_rd_hit;
  logic              ic_wr_en;
  mem_pkg::ic_idx_t  ic_wr_idx;
  mem_pkg::ic_tag_t  ic_wr_tag;
  mem_pkg::word_t    ic_wr_data;

  // per-side bus wires
  mem_pkg::bus_cmd_e i_command;
  mem_pkg::addr_t    i_addr;
  mem_pkg::mem_tag_t i_response;
  logic              i_reply;
  mem_pkg::bus_cmd_e d_command;
  mem_pkg::addr_t    d_addr;
  mem_pkg::word_t    d_data;
  mem_pkg::mem_tag_t d_response;
  logic              d_reply;

  icache_mem icache_mem_0 (
    .clock   (clock),
    .rst_n   (rst_n),
    .rd_idx  (ic_rd_idx),
    .rd_tag  (ic_rd_tag),
    .wr_en   (ic_wr_en),
    .wr_idx  (ic_wr_idx),
    .wr_tag  (ic_wr_tag),
    .wr_data (ic_wr_data),
    .rd_data (ic_rd_data),
    .rd_hit  (ic_rd_hit)
  );

  icache_ctrl icache_ctrl_0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .fetch_en      (fetch_en),
    .fetch_addr    (fetch_addr),
    .fetch_data    (fetch_data),
    .fetch_valid   (fetch_valid),
    .rd_idx        (ic_rd_idx),
    .rd_tag        (ic_rd_tag),
    .rd_data       (ic_rd_data),
    .rd_hit        (ic_rd_hit),
    .wr_en         (ic_wr_en),
    .wr_idx        (ic_wr_idx),
    .wr_tag        (ic_wr_tag),
    .wr_data       (ic_wr_data),
    .i_command     (i_command),
    .i_addr        (i_addr),
    .i_response    (i_response),
    .i_reply       (i_reply),
    .mem2proc_data (mem2proc_data),
    .mem2proc_tag  (mem2proc_tag)
  );

  mshr #(
    .MSHR_DEPTH (MSHR_DEPTH),
    .REQ_ID_W   (REQ_ID_W)
  ) mshr_0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .dreq_en       (dreq_en),
    .dreq_store    (dreq_store),
    .dreq_addr     (dreq_addr),
    .dreq_data     (dreq_data),
    .dreq_id       (dreq_id),
    .mshr_free     (mshr_free),
    .load_done     (load_done),
    .load_data     (load_data),
    .load_id       (load_id),
    .d_command     (d_command),
    .d_addr        (d_addr),
    .d_data        (d_data),
    .d_response    (d_response),
    .d_reply       (d_reply),
    .mem2proc_data (mem2proc_data),
    .mem2proc_tag  (mem2proc_tag)
  );

  mem_bus_arbiter arbiter_0 (
    .clock             (clock),
    .rst_n             (rst_n),
    .i_command         (i_command),
    .i_addr            (i_addr),
    .d_command         (d_command),
    .d_addr            (d_addr),
    .d_data            (d_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .i_response        (i_response),
    .d_response        (d_response),
    .i_reply           (i_reply),
    .d_reply           (d_reply)
  );

endmodule

`default_nettype wire

/* bench/mem_responder.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_responder (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              refuse_all,
  input  wire mem_pkg::bus_cmd_e proc2mem_command,
  input  wire mem_pkg::addr_t    proc2mem_addr,
  input  wire mem_pkg::word_t    proc2mem_data,
  output mem_pkg::mem_tag_t      mem2proc_response,
  output mem_pkg::word_t         mem2proc_data,
  output mem_pkg::mem_tag_t      mem2proc_tag
);

  localparam int N_WORDS = 8192;  // byte addresses 0x0000 to 0xffff

  mem_pkg::word_t    words   [N_WORDS];
  logic              refuse;     // random refusal for this cycle
  mem_pkg::mem_tag_t next_tag;
  mem_pkg::mem_tag_t rq_tag  [$];
  mem_pkg::word_t    rq_data [$];
  int                rq_due  [$];
  int                cycle;
  int                last_due;

  function automatic mem_pkg::word_t fill_word(input mem_pkg::addr_t a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ 64'h3c6e_f372_a54f_f53a;
  endfunction

  initial begin
    for (int i = 0; i < N_WORDS; i++) begin
      words[i] = fill_word(mem_pkg::addr_t'(i) << 3);
    end
    refuse        = 1'b0;
    next_tag      = 4'd1;
    mem2proc_tag  = '0;
    mem2proc_data = '0;
    cycle         = 0;
    last_due      = 0;
  end

  // accept or refuse in the same cycle as the command
  assign mem2proc_response = ((proc2mem_command != mem_pkg::BUS_NONE) && !refuse && !refuse_all)
                             ? next_tag : '0;

  always @(posedge clock or negedge rst_n) begin
    int due;
    if (!rst_n) begin
      refuse        <= 1'b0;
      next_tag      <= 4'd1;
      mem2proc_tag  <= '0;
      mem2proc_data <= '0;
      cycle         = 0;
      last_due      = 0;
      rq_tag.delete();
      rq_data.delete();
      rq_due.delete();
    end else begin
      cycle = cycle + 1;
      refuse <= ($urandom_range(3) == 0);  // one in four
      if (mem2proc_response != '0) begin
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        if (proc2mem_command == mem_pkg::BUS_STORE) begin
          words[proc2mem_addr[15:3]] = proc2mem_data;  // stores land at once
        end else begin
          due = cycle + $urandom_range(6, 2);
          if (due <= last_due) due = last_due + 1;  // replies stay in order
          last_due = due;
          rq_tag.push_back(mem2proc_response);
          rq_data.push_back(words[proc2mem_addr[15:3]]);
          rq_due.push_back(due);
        end
      end
      if ((rq_due.size() != 0) && (rq_due[0] <= cycle)) begin
        mem2proc_tag  <= rq_tag.pop_front();
        mem2proc_data <= rq_data.pop_front();
        void'(rq_due.pop_front());
      end else begin
        mem2proc_tag <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_mem_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

  localparam int MSHR_DEPTH  = mem_pkg::MSHR_DEPTH_DEF;
  localparam int REQ_ID_W    = mem_pkg::REQ_ID_W_DEF;
  localparam int N_FETCH     = 200;
  localparam int N_DATA      = 200;
  localparam int CYCLE_LIMIT = (N_FETCH + N_DATA) * 40;
  localparam mem_pkg::addr_t DATA_BASE = 64'h8000;

  logic                clock;
  logic                rst_n;
  logic                fetch_en;
  mem_pkg::addr_t      fetch_addr;
  mem_pkg::word_t      fetch_data;
  logic                fetch_valid;
  logic                dreq_en;
  logic                dreq_store;
  mem_pkg::addr_t      dreq_addr;
  mem_pkg::word_t      dreq_data;
  logic [REQ_ID_W-1:0] dreq_id;
  logic                mshr_free;
  logic                load_done;
  mem_pkg::word_t      load_data;
  logic [REQ_ID_W-1:0] load_id;
  mem_pkg::bus_cmd_e   proc2mem_command;
  mem_pkg::addr_t      proc2mem_addr;
  mem_pkg::word_t      proc2mem_data;
  mem_pkg::mem_tag_t   mem2proc_response;
  mem_pkg::word_t      mem2proc_data;
  mem_pkg::mem_tag_t   mem2proc_tag;
  logic                refuse_all;

  // reference model of the data region and the loads in flight
  mem_pkg::word_t      model_mem [16];
  logic [REQ_ID_W-1:0] exp_id    [$];
  mem_pkg::word_t      exp_data  [$];
  logic [REQ_ID_W-1:0] next_id;
  int                  loads_issued   = 0;
  int                  loads_done_cnt = 0;
  int                  data_waiting   = 0;  // queued and not yet accepted by memory
  logic                data_inflight  = 1'b0;
  int                  cycles         = 0;

  mem_system #(
    .MSHR_DEPTH (MSHR_DEPTH),
    .REQ_ID_W   (REQ_ID_W)
  ) UUT (
    .clock             (clock),
    .rst_n             (rst_n),
    .fetch_en          (fetch_en),
    .fetch_addr        (fetch_addr),
    .fetch_data        (fetch_data),
    .fetch_valid       (fetch_valid),
    .dreq_en           (dreq_en),
    .dreq_store        (dreq_store),
    .dreq_addr         (dreq_addr),
    .dreq_data         (dreq_data),
    .dreq_id           (dreq_id),
    .mshr_free         (mshr_free),
    .load_done         (load_done),
    .load_data         (load_data),
    .load_id           (load_id),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  mem_responder memory (
    .clock             (clock),
    .rst_n             (rst_n),
    .refuse_all        (refuse_all),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  // preloaded memory contents
  function automatic mem_pkg::word_t expected_fill(input mem_pkg::addr_t a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ 64'h3c6e_f372_a54f_f53a;
  endfunction

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input mem_pkg::word_t exp,
                            input mem_pkg::word_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_id(input string name, input logic [REQ_ID_W-1:0] exp,
                          input logic [REQ_ID_W-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_cmd(input string name, input mem_pkg::bus_cmd_e exp,
                           input mem_pkg::bus_cmd_e act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // fetch_addr is already on the port
  task automatic wait_fetch(input mem_pkg::addr_t a);
    while (!fetch_valid) @(posedge clock);
    check_word("fetch_data", expected_fill(a), fetch_data);
    fetch_en <= 1'b0;
  endtask

  // hold the address until the line is there
  task automatic fetch_one(input mem_pkg::addr_t a);
    @(posedge clock);
    fetch_en   <= 1'b1;
    fetch_addr <= a;
    @(posedge clock);
    wait_fetch(a);
  endtask

  task automatic send_data_req(input logic store, input int slot, input mem_pkg::word_t data);
    @(posedge clock);
    while (!mshr_free) @(posedge clock);
    dreq_en    <= 1'b1;
    dreq_store <= store;
    dreq_addr  <= DATA_BASE + mem_pkg::addr_t'(slot * 8);
    dreq_data  <= data;
    dreq_id    <= next_id;
    if (store) begin
      model_mem[slot] = data;
    end else begin
      exp_id.push_back(next_id);
      exp_data.push_back(model_mem[slot]);
      loads_issued++;
    end
    next_id++;
    @(posedge clock);
    dreq_en <= 1'b0;  // entry is counted before the next request
  endtask

  task automatic run_fetches();
    for (int n = 0; n < N_FETCH; n++) begin
      fetch_one(mem_pkg::addr_t'($urandom_range(63)) << 3);
    end
  endtask

  task automatic run_data_traffic();
    mem_pkg::word_t wd;
    for (int n = 0; n < N_DATA; n++) begin
      wd = {$urandom, $urandom};
      send_data_req(1'($urandom_range(1)), $urandom_range(15), wd);
      repeat ($urandom_range(3)) @(posedge clock);
    end
  endtask

  task automatic wait_data_idle();
    do begin
      @(negedge clock);
    end while ((data_waiting != 0) || data_inflight);
  endtask

  // fill every entry while memory refuses everything
  task automatic check_full_backpressure();
    @(posedge clock);
    refuse_all <= 1'b1;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      send_data_req(i % 2 == 0, i, {$urandom, $urandom});
    end
    @(posedge clock);
    check_flag("mshr_free", 1'b0, mshr_free);
    repeat (20) @(posedge clock);
    check_flag("mshr_free", 1'b0, mshr_free);
    refuse_all <= 1'b0;
    while (!mshr_free) @(posedge clock);
  endtask

  initial begin
    void'($urandom(32'hdb0e_14a1));
    rst_n      = 1'b0;
    fetch_en   = 1'b1;  // cold fetch of line 0 across reset
    fetch_addr = '0;
    dreq_en    = 1'b0;
    dreq_store = 1'b0;
    dreq_addr  = '0;
    dreq_data  = '0;
    dreq_id    = '0;
    refuse_all = 1'b0;
    next_id    = '0;
    for (int i = 0; i < 16; i++) begin
      model_mem[i] = expected_fill(DATA_BASE + mem_pkg::addr_t'(i * 8));
    end
    repeat (10) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);
    check_cmd("proc2mem_command", mem_pkg::BUS_NONE, proc2mem_command);
    check_flag("fetch_valid", 1'b0, fetch_valid);
    check_flag("load_done", 1'b0, load_done);
    check_flag("mshr_free", 1'b1, mshr_free);
    wait_fetch('0);
    fork
      run_fetches();
      run_data_traffic();
    join
    wait_data_idle();
    check_full_backpressure();
    wait_data_idle();
    repeat (20) @(negedge clock);
    if ((loads_done_cnt == loads_issued) && (exp_id.size() == 0)) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("load completions %0d do not match loads issued %0d",
               loads_done_cnt, loads_issued);
      stop_with_failure();
    end
  end

  // load results and bus ownership
  always @(posedge clock) begin : bus_monitor
    logic [REQ_ID_W-1:0] id_exp;
    mem_pkg::word_t      data_exp;
    if (rst_n) begin
      if (load_done) begin
        if (exp_id.size() == 0) begin
          $display("load_done pulsed at %0t with no load waiting for it", $time);
          stop_with_failure();
        end
        id_exp   = exp_id.pop_front();
        data_exp = exp_data.pop_front();
        check_id("load_id", id_exp, load_id);
        check_word("load_data", data_exp, load_data);
        loads_done_cnt++;
        data_inflight = 1'b0;  // next head may go out this cycle
      end
      // a waiting data head must own the bus
      if ((data_waiting != 0) && !data_inflight) begin
        if ((proc2mem_command == mem_pkg::BUS_NONE) || (proc2mem_addr < DATA_BASE)) begin
          $display("at %0t a data request was waiting but the bus did not carry it", $time);
          stop_with_failure();
        end
      end
      if ((proc2mem_command != mem_pkg::BUS_NONE) && (mem2proc_response != '0) &&
          (proc2mem_addr >= DATA_BASE)) begin
        data_waiting--;
        if (proc2mem_command == mem_pkg::BUS_LOAD) data_inflight = 1'b1;
      end
      if (dreq_en) data_waiting++;
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run hung", cycles);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

/* sim.f */
source/mem_pkg.sv
source/icache_mem.sv
source/icache_ctrl.sv
source/mshr.sv
source/mem_bus_arbiter.sv
source/mem_system.sv
bench/mem_responder.sv
bench/tb_mem_system.sv

/* Bender.yml */
package:
  name: mem_system

sources:
  - files:
      - source/mem_pkg.sv
      - source/icache_mem.sv
      - source/icache_ctrl.sv
      - source/mshr.sv
      - source/mem_bus_arbiter.sv
      - source/mem_system.sv
  - target: test
    files:
      - bench/mem_responder.sv
      - bench/tb_mem_system.sv
